// ==== src.f ====
verilog/icache_pkg.sv
verilog/tag_array.sv
verilog/line_array.sv
verilog/refill_master.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tb/axi_mem_model.sv
tb/tb_icache.sv

// ==== tb/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;

	logic                   aclk;
	logic                   rst_n;
	icache_pkg::ibus_req_t  ibus_req;
	icache_pkg::ibus_resp_t ibus_resp;
	logic [3:0]             arid, rid;
	logic [31:0]            araddr, rdata;
	logic [7:0]             arlen;
	logic [2:0]             arsize;
	logic [1:0]             arburst, rresp, ar_delay;
	logic                   arvalid, arready, rlast, rvalid, rready;
	logic                   accept;
	logic [31:0]            last_addr, delay_rng;
	int                     errors, ar_count, reads, tests_run, tests_failed;
	int                     err_mark, ar_mark;

	icache_top #(.ID_WIDTH(4)) i_icache_top (.*);

	axi_mem_model i_axi_mem_model (.clk(aclk), .*);

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	// new arready delay every cycle
	always @(posedge aclk) begin
		#1;
		delay_rng = xorshift(delay_rng);
		ar_delay  = delay_rng[1:0];
	end

	assign accept = ibus_req.valid && ibus_resp.ready;

	always @(posedge aclk) begin
		if (accept)
			last_addr <= ibus_req.addr;
		if (rst_n && arvalid && arready)
			ar_count++;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// expected {err, rdata} at byte address a
	// upper half is a[15:0] and lower half its inverse
	function automatic logic [32:0] expected_resp(input logic [31:0] a);
		if (a[20])
			return {1'b1, 32'h0};
		return {1'b0, a[15:0], ~a[15:0]};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("CHECK FAILED %0s: got %h expected %h", name, got, exp);
		errors++;
	endtask

	a_reset_state: assert property (@(posedge aclk)
		$rose(rst_n) |-> !ibus_resp.ready && !ibus_resp.valid && !arvalid && !rready)
		else report_mismatch("ibus_resp.ready/ibus_resp.valid/arvalid/rready",
			{$sampled(ibus_resp.ready), $sampled(ibus_resp.valid),
			$sampled(arvalid), $sampled(rready)}, 0);

	a_resp_timing: assert property (@(posedge aclk) disable iff (!rst_n)
		accept |=> ibus_resp.valid)
		else report_mismatch("ibus_resp.valid", $sampled(ibus_resp.valid), 1);

	a_resp_data: assert property (@(posedge aclk) disable iff (!rst_n)
		ibus_resp.valid |-> {ibus_resp.err, ibus_resp.rdata} == expected_resp(last_addr))
		else report_mismatch("ibus_resp.err/rdata",
			{$sampled(ibus_resp.err), $sampled(ibus_resp.rdata)},
			expected_resp($sampled(last_addr)));

	// INCR burst of four 32-bit beats
	a_ar_form: assert property (@(posedge aclk) disable iff (!rst_n)
		arvalid |-> {arid, arlen, arsize, arburst} == {4'h0, 8'd3, 3'd2, 2'd1})
		else report_mismatch("arid/arlen/arsize/arburst",
			{$sampled(arid), $sampled(arlen), $sampled(arsize), $sampled(arburst)},
			{4'h0, 8'd3, 3'd2, 2'd1});

	a_ar_addr: assert property (@(posedge aclk) disable iff (!rst_n)
		arvalid |-> araddr == {ibus_req.addr[31:4], 4'h0})
		else report_mismatch("araddr", $sampled(araddr),
			{$sampled(ibus_req.addr[31:4]), 4'h0});

	a_ar_held: assert property (@(posedge aclk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid)
		else report_mismatch("arvalid", $sampled(arvalid), 1);

	task automatic fetch(input logic [31:0] addr);
		int n;
		ibus_req.valid = 1'b1;
		ibus_req.addr  = addr;
		n = 0;
		@(negedge aclk);
		while (!ibus_resp.ready && n < 200) begin
			n++;
			@(negedge aclk);
		end
		if (!ibus_resp.ready) begin
			$display("timeout: fetch of address %h was never accepted", addr);
			$display("SOME TESTS FAILED");
			$finish;
		end
		@(posedge aclk);
		#1;
		ibus_req.valid = 1'b0;
		reads++;
		n = 0;
		@(negedge aclk);
		while (!ibus_resp.valid && n < 4) begin
			n++;
			@(negedge aclk);
		end
		if (!ibus_resp.valid) begin
			$display("timeout: no response for fetch of address %h", addr);
			$display("SOME TESTS FAILED");
			$finish;
		end
		@(posedge aclk);
		#1;
	endtask

	task automatic flush_cache();
		ibus_req.flush = 1'b1;
		@(posedge aclk);
		#1;
		ibus_req.flush = 1'b0;
	endtask

	task automatic start_test();
		err_mark = errors;
		ar_mark  = ar_count;
	endtask

	task automatic check_ars(input int exp);
		assert (ar_count - ar_mark == exp)
		else report_mismatch("ar_count", ar_count - ar_mark, exp);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0s: ok", name);
		end else begin
			tests_failed++;
			$display("test %0s: %0d check errors", name, errors - err_mark);
		end
	endtask

	initial begin
		logic [31:0] addr_rng;
		logic [31:0] a;
		int i;
		ibus_req     = '0;
		rst_n        = 1'b0;
		ar_delay     = 2'd0;
		delay_rng    = 32'h36bc;
		addr_rng     = 32'h36bc;
		errors       = 0;
		ar_count     = 0;
		reads        = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (16) @(posedge aclk);
		#1;
		rst_n = 1'b1;

		start_test();
		fetch(32'h0000_1234);
		check_ars(1);
		fetch(32'h0000_1230);
		fetch(32'h0000_1238);
		fetch(32'h0000_123c);
		check_ars(1);
		end_test("miss then hit");

		// last word of a line still gives a line-aligned AR
		start_test();
		fetch(32'h0000_567c);
		check_ars(1);
		end_test("burst form");

		// both map to index 4
		start_test();
		for (i = 0; i < 6; i++)
			fetch((i % 2) ? 32'h0000_3040 : 32'h0000_2040);
		check_ars(6);
		end_test("conflict eviction");

		start_test();
		flush_cache();
		fetch(32'h0000_1230);
		check_ars(1);
		end_test("flush");

		start_test();
		fetch(32'h0010_0080);
		fetch(32'h0010_0080);
		check_ars(2);
		end_test("error refill");

		// 512-byte window holds 32 lines over 16 slots
		start_test();
		for (i = 0; i < 64; i++) begin
			addr_rng = xorshift(addr_rng);
			a = 32'h0001_0000 | {23'd0, addr_rng[8:2], 2'b00};
			fetch(a);
		end
		assert (ar_count - ar_mark <= 64)
		else report_mismatch("ar_count", ar_count - ar_mark, 64);
		end_test("random traffic");

		$display("%0d tests, %0d failed, %0d check errors, %0d reads, %0d AR bursts",
			tests_run, tests_failed, errors, reads, ar_count);
		if (errors == 0 && tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [1:0]  ar_delay,
	input  logic [3:0]  arid,
	input  logic [31:0] araddr,
	input  logic [7:0]  arlen,
	input  logic        arvalid,
	output logic        arready,
	output logic [3:0]  rid,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready
);

	typedef enum logic [1:0] {M_IDLE, M_WAIT, M_ACCEPT, M_DATA} mem_state_e;

	mem_state_e  state;
	logic [1:0]  wait_cnt;
	logic [31:0] next_addr;
	logic [7:0]  beats_left;

	initial begin
		arready = 1'b0;
		rid     = '0;
		rdata   = '0;
		rresp   = 2'b00;
		rlast   = 1'b0;
		rvalid  = 1'b0;
	end

	// one R beat for byte address a, SLVERR when bit 20 is set
	task automatic put_beat(input logic [31:0] a, input logic last);
		rdata     <= {a[15:0], ~a[15:0]};
		rresp     <= a[20] ? 2'b10 : 2'b00;
		rlast     <= last;
		next_addr <= a + 32'd4;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			state   <= M_IDLE;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
		end else begin
			case (state)
				M_IDLE: begin
					if (arvalid) begin
						wait_cnt <= ar_delay;
						state    <= M_WAIT;
					end
				end
				M_WAIT: begin
					if (wait_cnt == 2'd0) begin
						arready <= 1'b1;
						state   <= M_ACCEPT;
					end else begin
						wait_cnt <= wait_cnt - 2'd1;
					end
				end
				M_ACCEPT: begin
					// AR handshake on this edge
					arready    <= 1'b0;
					rid        <= arid;
					rvalid     <= 1'b1;
					beats_left <= arlen;
					put_beat(araddr, arlen == 8'd0);
					state      <= M_DATA;
				end
				M_DATA: begin
					if (rready && rlast) begin
						rvalid <= 1'b0;
						rlast  <= 1'b0;
						state  <= M_IDLE;
					end else if (rready) begin
						beats_left <= beats_left - 8'd1;
						put_beat(next_addr, beats_left == 8'd1);
					end
				end
				default: begin
					state <= M_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
	parameter int ID_WIDTH = 4
) (
	input  logic                   aclk,
	input  logic                   rst_n,
	input  icache_pkg::ibus_req_t  ibus_req,
	output icache_pkg::ibus_resp_t ibus_resp,
	// AR channel
	output logic [ID_WIDTH-1:0]    arid,
	output logic [31:0]            araddr,
	output logic [7:0]             arlen,
	output logic [2:0]             arsize,
	output logic [1:0]             arburst,
	output logic                   arvalid,
	input  logic                   arready,
	// R channel
	input  logic [ID_WIDTH-1:0]    rid,
	input  logic [31:0]            rdata,
	input  logic [1:0]             rresp,
	input  logic                   rlast,
	input  logic                   rvalid,
	output logic                   rready
);

	wire clk = aclk;

	icache_pkg::axi_ar_t     ar;
	icache_pkg::axi_r_t      r;
	icache_pkg::cache_line_t refill_line;

	logic        hit;
	logic [31:0] rd_word;
	logic        rd_en;
	logic        miss_start;
	logic        refill_done;
	logic        refill_err;
	logic        tag_write;
	logic        line_write;
	logic        flush_all;

	// flatten the AR struct onto ports
	assign araddr  = ar.araddr;
	assign arlen   = ar.arlen;
	assign arsize  = ar.arsize;
	assign arburst = ar.arburst;
	assign arvalid = ar.arvalid;

	assign r.rdata  = rdata;
	assign r.rresp  = rresp;
	assign r.rlast  = rlast;
	assign r.rvalid = rvalid;

	icache_ctrl i_ctrl (
		.clk,
		.rst_n,
		.ibus_req,
		.ibus_resp,
		.hit,
		.rd_word,
		.miss_start,
		.refill_done,
		.refill_err,
		.tag_write,
		.line_write,
		.flush_all,
		.rd_en
	);

	tag_array i_tag_array (
		.clk,
		.rst_n,
		.addr(ibus_req.addr),
		.hit,
		.tag_write,
		.flush_all
	);

	line_array i_line_array (
		.clk,
		.addr(ibus_req.addr),
		.rd_en,
		.rd_word,
		.line_write,
		.refill_line
	);

	refill_master #(
		.ID_WIDTH(ID_WIDTH)
	) i_refill_master (
		.clk,
		.rst_n,
		.miss_addr(ibus_req.addr),
		.miss_start,
		.ar,
		.arid,
		.arready,
		.r,
		.rid,
		.rready,
		.refill_done,
		.refill_line,
		.refill_err
	);

endmodule

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  icache_pkg::ibus_req_t  ibus_req,
	output icache_pkg::ibus_resp_t ibus_resp,
	input  logic                   hit,
	input  logic [31:0]            rd_word,
	output logic                   miss_start,
	input  logic                   refill_done,
	input  logic                   refill_err,
	output logic                   tag_write,
	output logic                   line_write,
	output logic                   flush_all,
	output logic                   rd_en
);

	icache_pkg::cache_state_e state;
	icache_pkg::cache_state_e state_next;

	logic lookup;
	logic accept;
	logic err_pending;
	logic resp_valid;
	logic resp_err;

	assign lookup = (state == icache_pkg::S_LOOKUP);

	// flush wins over a fetch in the same cycle
	assign flush_all = lookup && ibus_req.flush;

	// a pending error lets the held request through once without a hit
	assign ibus_resp.ready = lookup && !ibus_req.flush && (hit || err_pending);
	assign accept          = ibus_req.valid && ibus_resp.ready;
	assign rd_en           = accept && !err_pending;

	assign miss_start = lookup && ibus_req.valid && !ibus_req.flush && !hit && !err_pending;

	assign tag_write  = (state == icache_pkg::S_INSTALL);
	assign line_write = (state == icache_pkg::S_INSTALL);

	always_comb begin
		state_next = state;
		case (state)
			icache_pkg::S_LOOKUP: begin
				if (miss_start)
					state_next = icache_pkg::S_REFILL;
			end
			icache_pkg::S_REFILL: begin
				if (refill_done) begin
					// bad line is dropped and the core gets the error
					if (refill_err)
						state_next = icache_pkg::S_LOOKUP;
					else
						state_next = icache_pkg::S_INSTALL;
				end
			end
			icache_pkg::S_INSTALL: begin
				state_next = icache_pkg::S_LOOKUP;
			end
			default: begin
				state_next = icache_pkg::S_LOOKUP;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= icache_pkg::S_LOOKUP;
			err_pending <= 1'b0;
			resp_valid  <= 1'b0;
			resp_err    <= 1'b0;
		end else begin
			state      <= state_next;
			resp_valid <= accept;
			resp_err   <= accept && err_pending;
			if (state == icache_pkg::S_REFILL && refill_done && refill_err)
				err_pending <= 1'b1;
			else if (accept)
				err_pending <= 1'b0;
		end
	end

	// one-cycle response with data from the registered word read
	assign ibus_resp.valid = resp_valid;
	assign ibus_resp.err   = resp_err;
	assign ibus_resp.rdata = resp_err ? 32'h0 : rd_word;

	// no fetch goes through right after a miss starts or a clean refill ends
	a_ready_in_lookup: assert property (
		@(posedge clk) disable iff (!rst_n)
		ibus_resp.ready |-> !$past(miss_start) && !$past(refill_done && !refill_err)
	);

	// install only follows a clean refill
	a_install_after_refill: assert property (
		@(posedge clk) disable iff (!rst_n)
		line_write |-> state == icache_pkg::S_INSTALL && $past(refill_done && !refill_err)
	);

endmodule

// ==== verilog/refill_master.sv ====
`timescale 1ns/1ps

module refill_master #(
	parameter int ID_WIDTH = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [31:0]             miss_addr,
	input  logic                    miss_start,
	output icache_pkg::axi_ar_t     ar,
	output logic [ID_WIDTH-1:0]     arid,
	input  logic                    arready,
	input  icache_pkg::axi_r_t      r,
	input  logic [ID_WIDTH-1:0]     rid,
	output logic                    rready,
	output logic                    refill_done,
	output icache_pkg::cache_line_t refill_line,
	output logic                    refill_err
);

	logic        arvalid_q;
	logic [31:0] line_addr;
	logic        rready_q;
	logic [1:0]  beat;
	logic        done_q;
	logic        err_q;
	logic        ar_fire;
	logic        r_fire;

	assign ar_fire = arvalid_q && arready;
	assign r_fire  = r.rvalid && rready_q;

	assign ar.araddr  = line_addr;
	assign ar.arlen   = icache_pkg::BURST_LEN;
	assign ar.arsize  = icache_pkg::SIZE_4B;
	assign ar.arburst = icache_pkg::BURST_INCR;
	assign ar.arvalid = arvalid_q;
	assign arid       = '0;
	assign rready     = rready_q;

	// handshake flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
			beat      <= 2'd0;
			done_q    <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			done_q <= r_fire && r.rlast;
			if (miss_start) begin
				arvalid_q <= 1'b1;
				err_q     <= 1'b0;
			end else if (ar_fire) begin
				arvalid_q <= 1'b0;
			end
			if (ar_fire) begin
				rready_q <= 1'b1;
				beat     <= 2'd0;
			end else if (r_fire) begin
				beat <= beat + 2'd1;
				if (r.rlast)
					rready_q <= 1'b0;
			end
			// any bad beat spoils the whole line
			if (r_fire && r.rresp != icache_pkg::RESP_OKAY)
				err_q <= 1'b1;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (miss_start)
			line_addr <= {miss_addr[31:icache_pkg::OFFSET_BITS], {icache_pkg::OFFSET_BITS{1'b0}}};
		if (r_fire)
			refill_line[beat] <= r.rdata;
	end

	assign refill_done = done_q;
	assign refill_err  = err_q;

	a_ar_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr)
	);

	a_rlast_on_beat3: assert property (
		@(posedge clk) disable iff (!rst_n)
		r_fire |-> (r.rlast == (beat == 2'd3))
	);

	a_rid_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		r_fire |-> rid == '0
	);

endmodule

// ==== verilog/line_array.sv ====
`timescale 1ns/1ps

module line_array (
	input  logic                    clk,
	input  logic [31:0]             addr,
	input  logic                    rd_en,
	output logic [31:0]             rd_word,
	input  logic                    line_write,
	input  icache_pkg::cache_line_t refill_line
);

	icache_pkg::cache_line_t lines [icache_pkg::NUM_LINES];

	logic [icache_pkg::INDEX_BITS-1:0] index;
	logic [icache_pkg::OFFSET_BITS-3:0] word_sel;

	assign index    = addr[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];
	assign word_sel = addr[icache_pkg::OFFSET_BITS-1:2];

	// whole line goes in at once after the burst
	always_ff @(posedge clk) begin
		if (line_write)
			lines[index] <= refill_line;
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rd_word <= lines[index][word_sel];
	end

endmodule

// ==== verilog/tag_array.sv ====
`timescale 1ns/1ps

module tag_array (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] addr,
	output logic        hit,
	input  logic        tag_write,
	input  logic        flush_all
);

	logic [icache_pkg::NUM_LINES-1:0] valid;
	logic [icache_pkg::TAG_BITS-1:0]  tags [icache_pkg::NUM_LINES];

	logic [icache_pkg::INDEX_BITS-1:0] index;
	logic [icache_pkg::TAG_BITS-1:0]   tag;

	assign index = addr[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];
	assign tag   = addr[icache_pkg::OFFSET_BITS + icache_pkg::INDEX_BITS +: icache_pkg::TAG_BITS];

	assign hit = valid[index] && (tags[index] == tag);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (flush_all) begin
			// every line dropped in one edge
			valid <= '0;
		end else if (tag_write) begin
			valid[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tag_write)
			tags[index] <= tag;
	end

	a_no_write_and_flush: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(tag_write && flush_all)
	);

endmodule

// ==== verilog/icache_pkg.sv ====
package icache_pkg;

	// cache geometry
	localparam int LINE_WORDS  = 4;
	localparam int NUM_LINES   = 16;
	localparam int OFFSET_BITS = 4;
	localparam int INDEX_BITS  = 4;
	localparam int TAG_BITS    = 24;

	// AXI4 read burst encodings
	localparam logic [7:0] BURST_LEN  = 8'd3;
	localparam logic [2:0] SIZE_4B    = 3'b010;
	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [1:0] RESP_OKAY  = 2'b00;

	typedef struct packed {
		logic        valid;
		logic        flush;
		logic [31:0] addr;
	} ibus_req_t;

	typedef struct packed {
		logic        ready;
		logic        valid;
		logic        err;
		logic [31:0] rdata;
	} ibus_resp_t;

	// AR channel, master side
	typedef struct packed {
		logic [31:0] araddr;
		logic [7:0]  arlen;
		logic [2:0]  arsize;
		logic [1:0]  arburst;
		logic        arvalid;
	} axi_ar_t;

	// R channel, slave side
	typedef struct packed {
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rlast;
		logic        rvalid;
	} axi_r_t;

	typedef logic [LINE_WORDS-1:0][31:0] cache_line_t;

	typedef enum logic [1:0] {
		S_LOOKUP,
		S_REFILL,
		S_INSTALL
	} cache_state_e;

endpackage
